// File: rtl/vic_load_pkg.sv
// shared widths, file kinds, memory map and requester ids, imported by every loader rtl file
package vic_load_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths and basic types
	//////////////////////////////////////////////////////////////////////

	localparam int DATA_W  = 8;
	localparam int MEM_AW  = 17;
	localparam int MACH_AW = 16;
	localparam int DL_AW   = 25;

	typedef logic [DATA_W-1:0]  byte_t;
	typedef logic [MEM_AW-1:0]  mem_addr_t;
	typedef logic [MACH_AW-1:0] mach_addr_t;
	typedef logic [DL_AW-1:0]   dl_addr_t;

	// download index values sent by the host menu
	localparam byte_t IDX_PRG = 8'h01;
	localparam byte_t IDX_CRT = 8'h41;
	localparam byte_t IDX_TAP = 8'hC1;

	//////////////////////////////////////////////////////////////////////
	// memory map
	//////////////////////////////////////////////////////////////////////

	// exclusive upper limits in machine space
	localparam mach_addr_t PRG_TOP = 16'hA000;
	localparam mach_addr_t CRT_TOP = 16'hC000;

	// tape image sits above the 64k machine space
	localparam mem_addr_t TAPE_BASE   = 17'h10000;
	localparam int        TAP_LEN_W   = 16;
	localparam dl_addr_t  TAP_VER_OFS = 25'h0C;

	// basic pointers rewritten after a prg load
	// even entries take the low byte of the end address, odd ones the high byte
	localparam int         FIX_N = 8;
	localparam mach_addr_t FIX_ADDR [FIX_N] = '{
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h00AE, 16'h00AF
	};

	// ram blocks 0,1,2,3 and 5 of the expansion map
	localparam int CART_BLK_N = 5;

	// peers of the shared image memory
	typedef enum logic [1:0] {REQ_MACH, REQ_LOAD, REQ_TAPE} req_id_t;

endpackage

// File: rtl/image_ram.sv
// single port byte ram holding machine space and tape space, read data registered
`timescale 1ns/1ps

module image_ram import vic_load_pkg::*; (
	input  logic      i_clk_sys,
	input  logic      i_en,
	input  logic      i_we,
	input  mem_addr_t i_addr,
	input  byte_t     i_wdata,
	output byte_t     o_rdata
);

	// lower half machine space, upper half tape image
	byte_t mem [2**MEM_AW];

	//////////////////////////////////////////////////////////////////////
	// access port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk_sys) begin
		if (i_en) begin
			if (i_we)
				mem[i_addr] <= i_wdata;
			else
				o_rdata <= mem[i_addr];
		end
	end

endmodule

// File: rtl/mem_arbiter.sv
// fixed priority arbiter for the shared image memory that puts the machine before the loader and the tape
`timescale 1ns/1ps

module mem_arbiter import vic_load_pkg::*; (
	input  logic       i_clk_sys,
	input  logic       i_reset,
	// machine read port
	input  logic       i_mach_valid,
	input  mach_addr_t i_mach_addr,
	output logic       o_mach_gnt,
	output logic       o_mach_rvalid,
	// loader write port
	input  logic       i_load_valid,
	input  mem_addr_t  i_load_addr,
	input  byte_t      i_load_wdata,
	output logic       o_load_gnt,
	// tape read port
	input  logic       i_tape_valid,
	input  mem_addr_t  i_tape_addr,
	output logic       o_tape_gnt,
	output logic       o_tape_rvalid,
	// memory side
	output logic       o_mem_en,
	output logic       o_mem_we,
	output mem_addr_t  o_mem_addr,
	output byte_t      o_mem_wdata
);

	req_id_t sel;
	req_id_t rd_owner;
	logic    rd_pend;

	//////////////////////////////////////////////////////////////////////
	// select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (i_mach_valid)
			sel = REQ_MACH;
		else if (i_load_valid)
			sel = REQ_LOAD;
		else
			sel = REQ_TAPE;
	end

	assign o_mem_en   = i_mach_valid | i_load_valid | i_tape_valid;
	// machine never waits
	assign o_mach_gnt = i_mach_valid;
	assign o_load_gnt = (sel == REQ_LOAD);
	assign o_tape_gnt = (sel == REQ_TAPE) & i_tape_valid;

	// the loader only writes and the other two only read
	always_comb begin
		o_mem_wdata = i_load_wdata;
		case (sel)
			REQ_MACH: begin
				o_mem_addr = {1'b0, i_mach_addr};
				o_mem_we   = 1'b0;
			end
			REQ_LOAD: begin
				o_mem_addr = i_load_addr;
				o_mem_we   = 1'b1;
			end
			default: begin
				o_mem_addr = i_tape_addr;
				o_mem_we   = 1'b0;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// read return routing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk_sys) begin
		if (i_reset)
			rd_pend <= 1'b0;
		else
			rd_pend <= o_mem_en & ~o_mem_we;
	end

	always_ff @(posedge i_clk_sys) begin
		if (o_mem_en)
			rd_owner <= sel;
	end

	assign o_mach_rvalid = rd_pend && (rd_owner == REQ_MACH);
	assign o_tape_rvalid = rd_pend && (rd_owner == REQ_TAPE);

	a_gnt_onehot: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		$onehot0({o_mach_gnt, o_load_gnt, o_tape_gnt}));

endmodule

// File: rtl/image_loader.sv
// turns the host download stream into image memory writes and runs the basic pointer fixup
`timescale 1ns/1ps

module image_loader import vic_load_pkg::*; (
	input  logic                  i_clk_sys,
	input  logic                  i_reset,
	// host download stream
	input  logic                  i_dl_active,
	input  byte_t                 i_dl_index,
	input  logic                  i_dl_valid,
	input  dl_addr_t              i_dl_addr,
	input  byte_t                 i_dl_data,
	output logic                  o_dl_ready,
	// write request towards the arbiter
	output logic                  o_req_valid,
	output mem_addr_t             o_req_addr,
	output byte_t                 o_req_wdata,
	input  logic                  i_gnt,
	// status
	output logic [CART_BLK_N-1:0] o_cart_blk,
	output logic [1:0]            o_tap_version,
	output logic                  o_tap_done,
	output logic [TAP_LEN_W-1:0]  o_tap_len
);

	logic                     kind_prg;
	logic                     kind_crt;
	logic                     kind_tap;
	logic                     is_hdr;
	logic                     store;
	logic                     dl_req;
	logic                     dl_fire;
	logic                     st_fire;
	logic                     win_close;
	logic                     win_open;
	logic                     active_d;
	byte_t                    kind_q;
	mach_addr_t               load_addr;
	mach_addr_t               limit;
	logic                     fix_busy;
	logic [$clog2(FIX_N)-1:0] fix_idx;
	logic [TAP_LEN_W-1:0]     tap_cnt;

	//////////////////////////////////////////////////////////////////////
	// byte decode
	//////////////////////////////////////////////////////////////////////

	assign kind_prg = (i_dl_index == IDX_PRG);
	assign kind_crt = (i_dl_index == IDX_CRT);
	assign kind_tap = (i_dl_index == IDX_TAP);
	assign limit    = kind_prg ? PRG_TOP : CRT_TOP;

	// first two bytes of prg and crt carry the load address
	assign is_hdr = (kind_prg | kind_crt) && (i_dl_addr < dl_addr_t'(2));

	always_comb begin
		if (kind_tap)
			store = (i_dl_addr[DL_AW-1:TAP_LEN_W] == '0);
		else
			store = (kind_prg | kind_crt) && !is_hdr && (load_addr < limit);
	end

	assign win_open  = i_dl_active & ~active_d;
	assign win_close = ~i_dl_active & active_d;

	// stored bytes wait for the grant while header and dropped bytes go straight through
	assign dl_req     = i_dl_active & i_dl_valid & store;
	assign o_dl_ready = ~fix_busy & (~dl_req | i_gnt);
	assign dl_fire    = i_dl_active & i_dl_valid & o_dl_ready;
	assign st_fire    = dl_fire & store;

	// the fixup owns the port while it runs and o_dl_ready holds the host off
	always_comb begin
		o_req_valid = fix_busy | dl_req;
		o_req_wdata = i_dl_data;
		if (fix_busy) begin
			o_req_addr  = {1'b0, FIX_ADDR[fix_idx]};
			o_req_wdata = fix_idx[0] ? load_addr[15:8] : load_addr[7:0];
		end else if (kind_tap) begin
			o_req_addr = TAPE_BASE + {1'b0, i_dl_addr[TAP_LEN_W-1:0]};
		end else begin
			o_req_addr = {1'b0, load_addr};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// control state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			active_d      <= 1'b0;
			kind_q        <= '0;
			fix_busy      <= 1'b0;
			fix_idx       <= '0;
			tap_cnt       <= '0;
			o_cart_blk    <= '0;
			o_tap_version <= '0;
			o_tap_done    <= 1'b0;
		end else begin
			active_d   <= i_dl_active;
			o_tap_done <= 1'b0;
			// index is only guaranteed while the window is open
			if (i_dl_active)
				kind_q <= i_dl_index;
			// stored tape byte count clears between windows
			if (!i_dl_active)
				tap_cnt <= '0;
			else if (st_fire && kind_tap)
				tap_cnt <= tap_cnt + 1'b1;
			if (st_fire && kind_tap && i_dl_addr == TAP_VER_OFS)
				o_tap_version <= i_dl_data[1:0];
			// new cartridge wipes the old block map
			if (win_open && kind_crt)
				o_cart_blk <= '0;
			if (st_fire && kind_crt) begin
				case (load_addr[15:13])
					3'd0: o_cart_blk[0] <= 1'b1;
					3'd1: o_cart_blk[1] <= 1'b1;
					3'd2: o_cart_blk[2] <= 1'b1;
					3'd3: o_cart_blk[3] <= 1'b1;
					3'd5: o_cart_blk[4] <= 1'b1;
					default: ;
				endcase
			end
			if (win_close && kind_q == IDX_TAP)
				o_tap_done <= 1'b1;
			// pointer sequencer issues one write per grant in list order
			if (win_close && kind_q == IDX_PRG) begin
				fix_busy <= 1'b1;
				fix_idx  <= '0;
			end else if (fix_busy && i_gnt) begin
				if (int'(fix_idx) == FIX_N - 1)
					fix_busy <= 1'b0;
				else
					fix_idx <= fix_idx + 1'b1;
			end
		end
	end

	// the running load address ends up as the clipped end address for the fixup
	always_ff @(posedge i_clk_sys) begin
		if (dl_fire && is_hdr) begin
			if (i_dl_addr[0])
				load_addr[15:8] <= i_dl_data;
			else
				load_addr[7:0] <= i_dl_data;
		end else if (st_fire && !kind_tap) begin
			load_addr <= load_addr + 1'b1;
		end
		if (win_close && kind_q == IDX_TAP)
			o_tap_len <= tap_cnt;
	end

	// granted stream writes stay inside the space of the window's file kind
	a_store_limit: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		o_req_valid && i_gnt && !fix_busy && !win_open |->
			((kind_q == IDX_TAP) ? o_req_addr[MEM_AW-1]
				: (!o_req_addr[MEM_AW-1] && o_req_addr[MACH_AW-1:0] <
					((kind_q == IDX_PRG) ? PRG_TOP : CRT_TOP))));

endmodule

// File: rtl/tape_player.sv
// plays the stored tape image out of image memory one byte at a time to the cassette side
`timescale 1ns/1ps

module tape_player import vic_load_pkg::*; (
	input  logic                 i_clk_sys,
	input  logic                 i_reset,
	// tape image info from the loader
	input  logic                 i_tap_done,
	input  logic [TAP_LEN_W-1:0] i_tap_len,
	input  logic                 i_tape_restart,
	// read request towards the arbiter
	output logic                 o_req_valid,
	output mem_addr_t            o_req_addr,
	input  logic                 i_gnt,
	input  logic                 i_rvalid,
	input  byte_t                i_rdata,
	// cassette consumer
	output logic                 o_tape_valid,
	output byte_t                o_tape_data,
	input  logic                 i_tape_ready,
	output logic                 o_tape_loaded
);

	logic [TAP_LEN_W-1:0] pos;
	logic [TAP_LEN_W-1:0] len;
	logic                 wait_data;

	// pos only moves on acceptance so the address holds while requesting
	assign o_req_addr    = TAPE_BASE + {1'b0, pos};
	// bytes still to deliver
	assign o_tape_loaded = (pos < len);

	//////////////////////////////////////////////////////////////////////
	// fetch sequence
	// request -> wait for read data -> hold for consumer -> next
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk_sys) begin
		if (i_reset) begin
			pos          <= '0;
			len          <= '0;
			o_req_valid  <= 1'b0;
			wait_data    <= 1'b0;
			o_tape_valid <= 1'b0;
		end else if (i_tap_done || i_tape_restart) begin
			// rewind and abandon any fetch in flight
			if (i_tap_done)
				len <= i_tap_len;
			pos          <= '0;
			o_req_valid  <= 1'b0;
			wait_data    <= 1'b0;
			o_tape_valid <= 1'b0;
		end else begin
			if (o_req_valid) begin
				if (i_gnt) begin
					o_req_valid <= 1'b0;
					wait_data   <= 1'b1;
				end
			end else if (wait_data) begin
				// read data arrives on the cycle after the grant
				if (i_rvalid) begin
					wait_data    <= 1'b0;
					o_tape_valid <= 1'b1;
				end
			end else if (o_tape_valid) begin
				if (i_tape_ready) begin
					o_tape_valid <= 1'b0;
					pos          <= pos + 1'b1;
				end
			end else if (o_tape_loaded) begin
				o_req_valid <= 1'b1;
			end
		end
	end

	// output byte register
	always_ff @(posedge i_clk_sys) begin
		if (wait_data && i_rvalid)
			o_tape_data <= i_rdata;
	end

	// a stalled byte stays offered and unchanged
	a_tape_hold: assert property (@(posedge i_clk_sys) disable iff (i_reset)
		o_tape_valid && !i_tape_ready && !i_tape_restart && !i_tap_done
		|=> o_tape_valid && $stable(o_tape_data));

endmodule

// File: rtl/vic_load_top.sv
// loading subsystem top, joins loader, tape player and machine port onto the image ram
`timescale 1ns/1ps

module vic_load_top import vic_load_pkg::*; (
	input  logic                  i_clk_sys,
	input  logic                  i_reset,
	// host download
	input  logic                  i_dl_active,
	input  byte_t                 i_dl_index,
	input  logic                  i_dl_valid,
	input  dl_addr_t              i_dl_addr,
	input  byte_t                 i_dl_data,
	output logic                  o_dl_ready,
	// machine read port
	input  logic                  i_mach_valid,
	input  mach_addr_t            i_mach_addr,
	output logic                  o_mach_ready,
	output logic                  o_mach_rvalid,
	output byte_t                 o_mach_rdata,
	// cassette side
	output logic                  o_tape_valid,
	output byte_t                 o_tape_data,
	input  logic                  i_tape_ready,
	input  logic                  i_tape_restart,
	output logic                  o_tape_loaded,
	// status
	output logic [CART_BLK_N-1:0] o_cart_blk,
	output logic [1:0]            o_tap_version
);

	logic                 load_valid;
	mem_addr_t            load_addr;
	byte_t                load_wdata;
	logic                 load_gnt;
	logic                 tape_valid;
	mem_addr_t            tape_addr;
	logic                 tape_gnt;
	logic                 tape_rvalid;
	logic                 tap_done;
	logic [TAP_LEN_W-1:0] tap_len;
	logic                 mem_en;
	logic                 mem_we;
	mem_addr_t            mem_addr;
	byte_t                mem_wdata;
	byte_t                mem_rdata;

	// read data is shared, the rvalid strobes pick the owner
	assign o_mach_rdata = mem_rdata;

	//////////////////////////////////////////////////////////////////////
	// peers
	//////////////////////////////////////////////////////////////////////

	image_loader u_image_loader (
		.i_clk_sys     (i_clk_sys),
		.i_reset       (i_reset),
		.i_dl_active   (i_dl_active),
		.i_dl_index    (i_dl_index),
		.i_dl_valid    (i_dl_valid),
		.i_dl_addr     (i_dl_addr),
		.i_dl_data     (i_dl_data),
		.o_dl_ready    (o_dl_ready),
		.o_req_valid   (load_valid),
		.o_req_addr    (load_addr),
		.o_req_wdata   (load_wdata),
		.i_gnt         (load_gnt),
		.o_cart_blk    (o_cart_blk),
		.o_tap_version (o_tap_version),
		.o_tap_done    (tap_done),
		.o_tap_len     (tap_len)
	);

	tape_player u_tape_player (
		.i_clk_sys      (i_clk_sys),
		.i_reset        (i_reset),
		.i_tap_done     (tap_done),
		.i_tap_len      (tap_len),
		.i_tape_restart (i_tape_restart),
		.o_req_valid    (tape_valid),
		.o_req_addr     (tape_addr),
		.i_gnt          (tape_gnt),
		.i_rvalid       (tape_rvalid),
		.i_rdata        (mem_rdata),
		.o_tape_valid   (o_tape_valid),
		.o_tape_data    (o_tape_data),
		.i_tape_ready   (i_tape_ready),
		.o_tape_loaded  (o_tape_loaded)
	);

	//////////////////////////////////////////////////////////////////////
	// shared memory
	//////////////////////////////////////////////////////////////////////

	mem_arbiter u_mem_arbiter (
		.i_clk_sys     (i_clk_sys),
		.i_reset       (i_reset),
		.i_mach_valid  (i_mach_valid),
		.i_mach_addr   (i_mach_addr),
		.o_mach_gnt    (o_mach_ready),
		.o_mach_rvalid (o_mach_rvalid),
		.i_load_valid  (load_valid),
		.i_load_addr   (load_addr),
		.i_load_wdata  (load_wdata),
		.o_load_gnt    (load_gnt),
		.i_tape_valid  (tape_valid),
		.i_tape_addr   (tape_addr),
		.o_tape_gnt    (tape_gnt),
		.o_tape_rvalid (tape_rvalid),
		.o_mem_en      (mem_en),
		.o_mem_we      (mem_we),
		.o_mem_addr    (mem_addr),
		.o_mem_wdata   (mem_wdata)
	);

	image_ram u_image_ram (
		.i_clk_sys (i_clk_sys),
		.i_en      (mem_en),
		.i_we      (mem_we),
		.i_addr    (mem_addr),
		.i_wdata   (mem_wdata),
		.o_rdata   (mem_rdata)
	);

endmodule

// File: testbench/tb_clock.sv
// testbench clock and reset source, instantiated once by the testbench top
`timescale 1ns/1ps

module tb_clock (
	output logic o_clk_sys,
	output logic o_reset
);

	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 16;

	// 100 ns period
	initial begin
		o_clk_sys = 1'b0;
		forever #HALF_PERIOD o_clk_sys = ~o_clk_sys;
	end

	// reset released just after an edge, like every other input
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk_sys);
		#1 o_reset = 1'b0;
	end

endmodule

// File: testbench/tb_vic_load.sv
// testbench for the loading subsystem that streams random files and checks the DUT against a shadow model
`timescale 1ns/1ps

module tb_vic_load import vic_load_pkg::*; ();

	localparam logic [31:0] SEED      = 32'h32900f71;
	localparam int          DRIVE_DLY = 1;
	localparam int          READS_N   = 40;

	logic                  clk_sys;
	logic                  reset;
	logic                  i_dl_active;
	byte_t                 i_dl_index;
	logic                  i_dl_valid;
	dl_addr_t              i_dl_addr;
	byte_t                 i_dl_data;
	logic                  o_dl_ready;
	logic                  i_mach_valid;
	mach_addr_t            i_mach_addr;
	logic                  o_mach_ready;
	logic                  o_mach_rvalid;
	byte_t                 o_mach_rdata;
	logic                  o_tape_valid;
	byte_t                 o_tape_data;
	logic                  i_tape_ready;
	logic                  i_tape_restart;
	logic                  o_tape_loaded;
	logic [CART_BLK_N-1:0] o_cart_blk;
	logic [1:0]            o_tap_version;

	// shadow model of memory and status
	byte_t                 shadow [mem_addr_t];
	mach_addr_t            known_q [$];
	logic [CART_BLK_N-1:0] blk_m;
	logic [1:0]            ver_m;
	int                    tape_len_m;
	// file being streamed
	byte_t                 file_q [$];
	int unsigned           cycles;
	int unsigned           cycle_limit = 32'hFFFF_FFFF;

	tb_clock u_tb_clock (
		.o_clk_sys (clk_sys),
		.o_reset   (reset)
	);

	vic_load_top i_vic_load_top (
		.i_clk_sys      (clk_sys),
		.i_reset        (reset),
		.i_dl_active    (i_dl_active),
		.i_dl_index     (i_dl_index),
		.i_dl_valid     (i_dl_valid),
		.i_dl_addr      (i_dl_addr),
		.i_dl_data      (i_dl_data),
		.o_dl_ready     (o_dl_ready),
		.i_mach_valid   (i_mach_valid),
		.i_mach_addr    (i_mach_addr),
		.o_mach_ready   (o_mach_ready),
		.o_mach_rvalid  (o_mach_rvalid),
		.o_mach_rdata   (o_mach_rdata),
		.o_tape_valid   (o_tape_valid),
		.o_tape_data    (o_tape_data),
		.i_tape_ready   (i_tape_ready),
		.i_tape_restart (i_tape_restart),
		.o_tape_loaded  (o_tape_loaded),
		.o_cart_blk     (o_cart_blk),
		.o_tap_version  (o_tap_version)
	);

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("test failed");
		$display("%s", why);
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic compare_addr(input string name, input mach_addr_t got, input mach_addr_t exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic compare_blk(input string name, input logic [CART_BLK_N-1:0] got,
		input logic [CART_BLK_N-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic compare_ver(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	// run length is bounded by the amount of streamed data
	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= cycle_limit)
			fail_run($sformatf("timeout: no progress from the DUT after %0d cycles", cycles));
	end

	//////////////////////////////////////////////////////////////////////
	// model
	//////////////////////////////////////////////////////////////////////

	function automatic void shadow_write(input mem_addr_t a, input byte_t d);
		shadow[a] = d;
		if (!a[MEM_AW-1])
			known_q.push_back(a[MACH_AW-1:0]);
	endfunction

	// only blocks 0..3 and 5 of the expansion map carry a flag
	function automatic logic [CART_BLK_N-1:0] block_flag(input mach_addr_t a);
		case (a[15:13])
			3'd0: return 5'b00001;
			3'd1: return 5'b00010;
			3'd2: return 5'b00100;
			3'd3: return 5'b01000;
			3'd5: return 5'b10000;
			default: return 5'b00000;
		endcase
	endfunction

	// prg and crt files open with the two load address bytes before the body
	function automatic void build_image(input mach_addr_t load, input int len);
		file_q.delete();
		file_q.push_back(load[7:0]);
		file_q.push_back(load[15:8]);
		repeat (len)
			file_q.push_back(byte_t'($urandom));
	endfunction

	function automatic void build_tape(input int len);
		file_q.delete();
		repeat (len)
			file_q.push_back(byte_t'($urandom));
	endfunction

	function automatic mach_addr_t apply_image(input byte_t index);
		mach_addr_t a;
		mach_addr_t top;
		mach_addr_t end_a;
		int         full;
		if (index == IDX_TAP) begin
			for (int k = 0; k < file_q.size(); k++) begin
				shadow_write(mem_addr_t'(TAPE_BASE + k), file_q[k]);
				if (k == int'(TAP_VER_OFS))
					ver_m = file_q[k][1:0];
			end
			tape_len_m = file_q.size();
			return '0;
		end
		top  = (index == IDX_PRG) ? PRG_TOP : CRT_TOP;
		a    = {file_q[1], file_q[0]};
		full = int'(a) + file_q.size() - 2;
		if (index == IDX_CRT)
			blk_m = '0;
		for (int k = 2; k < file_q.size(); k++) begin
			if (a < top) begin
				shadow_write({1'b0, a}, file_q[k]);
				if (index == IDX_CRT)
					blk_m = blk_m | block_flag(a);
				a = a + 16'd1;
			end
		end
		// end pointer is the clipped end of the program
		end_a = (full < int'(PRG_TOP)) ? mach_addr_t'(full) : PRG_TOP;
		if (index == IDX_PRG)
			for (int i = 0; i < FIX_N; i++)
				shadow_write({1'b0, FIX_ADDR[i]}, (i % 2 == 1) ? end_a[15:8] : end_a[7:0]);
		return end_a;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// drivers that start and end just after a rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge clk_sys);
		#DRIVE_DLY;
	endtask

	task automatic stream_file(input byte_t index);
		logic took;
		i_dl_index  = index;
		i_dl_active = 1'b1;
		for (int k = 0; k < file_q.size(); k++) begin
			repeat ($urandom % 3) step();
			i_dl_valid = 1'b1;
			i_dl_addr  = dl_addr_t'(k);
			i_dl_data  = file_q[k];
			do begin
				@(negedge clk_sys);
				took = o_dl_ready;
				step();
			end while (!took);
			i_dl_valid = 1'b0;
		end
		step();
		i_dl_active = 1'b0;
		step();
		if (index == IDX_PRG) begin
			// the fixup has started and holds the host off until it ends
			@(negedge clk_sys);
			if (o_dl_ready)
				fail_run("o_dl_ready was high while the pointer fixup was pending");
			do begin
				@(negedge clk_sys);
				took = o_dl_ready;
				step();
			end while (!took);
		end
		// let the player pick up the new length
		if (index == IDX_TAP)
			step();
	endtask

	// data must follow ready by exactly one cycle
	task automatic mach_read(input mach_addr_t a, output byte_t d);
		i_mach_valid = 1'b1;
		i_mach_addr  = a;
		@(negedge clk_sys);
		compare_bit("o_mach_ready", o_mach_ready, 1'b1);
		compare_bit("o_mach_rvalid", o_mach_rvalid, 1'b0);
		step();
		i_mach_valid = 1'b0;
		@(negedge clk_sys);
		compare_bit("o_mach_rvalid", o_mach_rvalid, 1'b1);
		d = o_mach_rdata;
		step();
	endtask

	task automatic check_range(input mach_addr_t start, input int n);
		mach_addr_t a;
		byte_t      d;
		for (int k = 0; k < n; k++) begin
			a = start + mach_addr_t'(k);
			if (shadow.exists({1'b0, a})) begin
				mach_read(a, d);
				compare_byte($sformatf("o_mach_rdata at %h", a), d, shadow[{1'b0, a}]);
			end
		end
	endtask

	task automatic check_pointers(input mach_addr_t exp_end);
		byte_t lo;
		byte_t hi;
		for (int i = 0; i < FIX_N / 2; i++) begin
			mach_read(FIX_ADDR[2*i], lo);
			mach_read(FIX_ADDR[2*i+1], hi);
			compare_addr($sformatf("o_mach_rdata pointer at %h", FIX_ADDR[2*i]), {hi, lo},
				exp_end);
		end
	endtask

	// machine space reads that no concurrent traffic writes
	task automatic random_reads(input int n);
		mach_addr_t a;
		byte_t      d;
		repeat (n) begin
			repeat ($urandom % 4) step();
			a = known_q[$urandom % known_q.size()];
			mach_read(a, d);
			compare_byte($sformatf("o_mach_rdata at %h", a), d, shadow[{1'b0, a}]);
		end
	endtask

	task automatic consume_tape(input int n);
		int idx;
		idx = 0;
		while (idx < n) begin
			i_tape_ready = ($urandom % 4) != 0;
			@(negedge clk_sys);
			if (o_tape_valid && i_tape_ready) begin
				compare_bit("o_tape_loaded", o_tape_loaded, 1'b1);
				compare_byte($sformatf("o_tape_data byte %0d", idx), o_tape_data,
					shadow[mem_addr_t'(TAPE_BASE + idx)]);
				idx++;
			end
			step();
		end
		i_tape_ready = 1'b0;
	endtask

	task automatic check_tape_end();
		@(negedge clk_sys);
		compare_bit("o_tape_loaded", o_tape_loaded, 1'b0);
		compare_bit("o_tape_valid", o_tape_valid, 1'b0);
		step();
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		mach_addr_t prg1_load;
		mach_addr_t prg2_load;
		mach_addr_t crt0_load;
		mach_addr_t crt_load [3];
		mach_addr_t end_a;
		int         prg1_len;
		int         prg2_len;
		int         crt0_len;
		int         crt_len [3];
		int         tap1_len;
		int         tap2_len;
		int         total;
		void'($urandom(SEED));
		prg1_load = mach_addr_t'(32'h0800 + $urandom % 32'h6000);
		prg1_len  = 32 + int'($urandom % 160);
		// crt0 fills the area just above the prg limit before prg2 overruns it
		crt0_load = mach_addr_t'(32'h9F00 + $urandom % 32'h80);
		crt0_len  = 320 + int'($urandom % 64);
		prg2_load = mach_addr_t'(32'hA000 - 16 - $urandom % 48);
		prg2_len  = 80 + int'($urandom % 80);
		for (int i = 0; i < 3; i++) begin
			crt_load[i] = mach_addr_t'(($urandom % 6) * 32'h2000 + 32'h0100 + $urandom % 32'h1E00);
			crt_len[i]  = 16 + int'($urandom % 200);
		end
		tap1_len = 24 + int'($urandom % 200);
		tap2_len = 24 + int'($urandom % 200);
		total = prg1_len + crt0_len + prg2_len + 6 + tap1_len + tap2_len;
		for (int i = 0; i < 3; i++)
			total += crt_len[i] + 2;
		cycle_limit = total * 20 + 2000;

		i_dl_active    = 1'b0;
		i_dl_index     = '0;
		i_dl_valid     = 1'b0;
		i_dl_addr      = '0;
		i_dl_data      = '0;
		i_mach_valid   = 1'b0;
		i_mach_addr    = '0;
		i_tape_ready   = 1'b0;
		i_tape_restart = 1'b0;
		blk_m          = '0;
		ver_m          = '0;
		tape_len_m     = 0;
		wait (reset == 1'b0);
		step();
		@(negedge clk_sys);
		compare_bit("o_dl_ready", o_dl_ready, 1'b1);
		compare_bit("o_tape_loaded", o_tape_loaded, 1'b0);
		compare_bit("o_tape_valid", o_tape_valid, 1'b0);
		compare_bit("o_mach_rvalid", o_mach_rvalid, 1'b0);
		compare_blk("o_cart_blk", o_cart_blk, '0);
		compare_ver("o_tap_version", o_tap_version, '0);
		step();

		// prg load with pointer fixup
		build_image(prg1_load, prg1_len);
		end_a = apply_image(IDX_PRG);
		stream_file(IDX_PRG);
		check_range(prg1_load, prg1_len);
		check_pointers(end_a);

		// prg past its limit leaves the cartridge bytes above it alone
		build_image(crt0_load, crt0_len);
		end_a = apply_image(IDX_CRT);
		stream_file(IDX_CRT);
		build_image(prg2_load, prg2_len);
		end_a = apply_image(IDX_PRG);
		stream_file(IDX_PRG);
		check_range(prg2_load, prg2_len);
		check_pointers(end_a);

		// cartridges in random blocks
		for (int i = 0; i < 3; i++) begin
			build_image(crt_load[i], crt_len[i]);
			end_a = apply_image(IDX_CRT);
			stream_file(IDX_CRT);
			compare_blk("o_cart_blk", o_cart_blk, blk_m);
			check_range(crt_load[i], crt_len[i]);
		end

		// tape store and playback
		build_tape(tap1_len);
		end_a = apply_image(IDX_TAP);
		stream_file(IDX_TAP);
		compare_ver("o_tap_version", o_tap_version, ver_m);
		consume_tape(tape_len_m);
		check_tape_end();

		// machine reads mixed into a download and into playback around a rewind
		build_tape(tap2_len);
		end_a = apply_image(IDX_TAP);
		fork
			stream_file(IDX_TAP);
			random_reads(READS_N);
		join
		compare_ver("o_tap_version", o_tap_version, ver_m);
		fork
			consume_tape(tape_len_m / 2);
			random_reads(READS_N);
		join
		i_tape_restart = 1'b1;
		step();
		i_tape_restart = 1'b0;
		fork
			begin
				consume_tape(tape_len_m);
				check_tape_end();
			end
			random_reads(READS_N);
		join

		$display("test passed");
		$finish;
	end

endmodule

// File: vic_load_top.f
rtl/vic_load_pkg.sv
rtl/image_ram.sv
rtl/mem_arbiter.sv
rtl/image_loader.sv
rtl/tape_player.sv
rtl/vic_load_top.sv
testbench/tb_clock.sv
testbench/tb_vic_load.sv

// File: Makefile
# Verilator build and run of the loading subsystem testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_vic_load
FILELIST  ?= vic_load_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
